//--- hw/sortPkg.sv
package sortPkg;

	// ********************
	// data words and counts

	typedef logic [15:0] word_t;   // one unsigned sort key
	typedef logic [5:0] len_t;     // element count, 0 to 32

	// ********************
	// job and stream beats

	typedef struct packed {
		logic [31:0] readAddress;   // first source word
		logic [31:0] writeAddress;  // first result word
		len_t length;
	} job_t;

	typedef struct packed {
		logic valid;
		word_t data;
	} sortedBeat_t;

endpackage

//--- hw/busPkg.sv
package busPkg;

	// master side, held until waitRequest is low
	typedef struct packed {
		logic read;
		logic write;
		logic [31:0] address;
		logic [15:0] writeData;
	} memReq_t;

	// slave side
	typedef struct packed {
		logic waitRequest;
		logic readDataValid;   // in order, no back-pressure
		logic [15:0] readData;
	} memRsp_t;

endpackage

//--- hw/runQueue.sv
`timescale 1ns/100ps

module runQueue #(
	parameter int Depth = 16
) (
	input logic clk,
	input logic reset_n,
	input logic clear,
	input logic push,
	input sortPkg::word_t pushData,
	input logic pop,
	output sortPkg::word_t head,
	output logic [$clog2(Depth + 1) - 1:0] count
);
	import sortPkg::*;

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

	word_t store [Depth];
	logic [PtrW - 1:0] rdPtr;
	logic [PtrW - 1:0] wrPtr;

	function automatic logic [PtrW - 1:0] nextPtr(input logic [PtrW - 1:0] ptr);
		return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;   // wrap for any depth
	endfunction

	assign head = store[rdPtr];   // oldest word, valid while count != 0

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			store[wrPtr] <= pushData;
	end

	// merge control must never overrun or drain a queue
	noOverflow: assert property (@(posedge clk) disable iff (!reset_n) push |-> count < Depth);
	noUnderflow: assert property (@(posedge clk) disable iff (!reset_n) pop |-> count != 0);

endmodule

//--- hw/blockLoader.sv
`timescale 1ns/100ps

module blockLoader (
	input logic clk,
	input logic reset_n,
	input logic start,
	input sortPkg::job_t job,
	input busPkg::memRsp_t memRsp,
	output busPkg::memReq_t memReq,
	output sortPkg::sortedBeat_t loadBeat
);
	import sortPkg::*;

	logic busy;
	logic accepted;
	len_t issued;          // reads accepted so far
	logic [31:0] address;

	assign accepted = busy && !memRsp.waitRequest;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			issued <= '0;
		end else if (start) begin
			busy <= 1'b1;
			issued <= '0;
		end else if (accepted) begin
			issued <= issued + 1'b1;
			if (issued == job.length - 1'b1)
				busy <= 1'b0;   // last read taken
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			address <= job.readAddress;
		else if (accepted)
			address <= address + 32'd1;
	end

	always_comb begin
		memReq = '0;
		memReq.read = busy;
		memReq.address = address;
	end

	// returned data goes straight into the engine
	always_comb begin
		loadBeat.valid = memRsp.readDataValid;
		loadBeat.data = memRsp.readData;
	end

endmodule

//--- hw/mergeEngine.sv
`timescale 1ns/100ps

module mergeEngine #(
	parameter int MaxLength = 32
) (
	input logic clk,
	input logic reset_n,
	input logic start,
	input sortPkg::job_t job,
	input sortPkg::sortedBeat_t loadBeat,
	output sortPkg::sortedBeat_t sortedBeat,
	input logic sortedReady
);
	import sortPkg::*;

	localparam int Depth = MaxLength / 2;
	localparam int CountW = $clog2(Depth + 1);

	typedef enum logic [1:0] {stIdle, stLoad, stMerge, stFinal} state_t;

	state_t state;
	len_t loaded;
	len_t runSize;
	len_t leftA;        // words left in the current A run
	len_t leftB;
	logic loadSel;      // 1B takes the next loaded word
	logic srcSide;      // 0: read 1A/1B, write 2A/2B
	logic dstB;

	// queue index: 0 = 1A, 1 = 1B, 2 = 2A, 3 = 2B
	logic [3:0] qPush;
	logic [3:0] qPop;
	word_t qHead [4];
	logic [CountW - 1:0] qCount [4];
	word_t pushWord;
	word_t mergeWord;
	logic [1:0] srcA;
	logic [1:0] srcB;
	logic takeA;
	logic passEnd;
	logic boundary;
	logic step;

	// ********************
	// head compare

	assign srcA = {srcSide, 1'b0};
	assign srcB = {srcSide, 1'b1};
	assign takeA = (leftA != 0) && (leftB == 0 || qHead[srcA] <= qHead[srcB]);   // tie goes to A
	assign mergeWord = takeA ? qHead[srcA] : qHead[srcB];
	assign passEnd = (qCount[srcA] == 0) && (qCount[srcB] == 0);
	assign boundary = (leftA == 0) && (leftB == 0);
	assign step = (state == stMerge && !passEnd && !boundary) || (sortedBeat.valid && sortedReady);
	assign pushWord = (state == stLoad) ? loadBeat.data : mergeWord;

	always_comb begin
		sortedBeat.valid = (state == stFinal) && !passEnd;   // last pass streams out
		sortedBeat.data = mergeWord;
	end

	always_comb begin
		qPush = '0;
		qPop = '0;
		if (state == stLoad && loadBeat.valid)
			qPush[{1'b0, loadSel}] = 1'b1;
		if (state == stMerge && step)
			qPush[{~srcSide, dstB}] = 1'b1;
		if (step)
			qPop[takeA ? srcA : srcB] = 1'b1;
	end

	// ********************
	// pass control

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= stIdle;
			loaded <= '0;
			runSize <= '0;
			leftA <= '0;
			leftB <= '0;
			loadSel <= 1'b0;
			srcSide <= 1'b0;
			dstB <= 1'b0;
		end else if (start) begin
			state <= stLoad;
			loaded <= '0;
			loadSel <= 1'b0;
		end else begin
			if (step && takeA)
				leftA <= leftA - 1'b1;
			else if (step)
				leftB <= leftB - 1'b1;
			case (state)
				stLoad: if (loadBeat.valid) begin
					loaded <= loaded + 1'b1;
					loadSel <= ~loadSel;
					if (loaded == job.length - 1'b1) begin   // runs of one word each
						state <= (job.length == 6'd2) ? stFinal : stMerge;
						runSize <= 6'd1;
						leftA <= 6'd1;
						leftB <= 6'd1;
						srcSide <= 1'b0;
						dstB <= 1'b0;
					end
				end
				stMerge: if (passEnd) begin
					runSize <= runSize << 1;
					leftA <= runSize << 1;
					leftB <= runSize << 1;
					srcSide <= ~srcSide;
					dstB <= 1'b0;
					if (runSize == (job.length >> 2))
						state <= stFinal;
				end else if (boundary) begin
					leftA <= runSize;   // costs one cycle
					leftB <= runSize;
					dstB <= ~dstB;
				end else if (runSize == 6'd1 && (leftA == 0 || leftB == 0)) begin
					leftA <= 6'd1;      // single-word pairs reload inline
					leftB <= 6'd1;
					dstB <= ~dstB;
				end
				stFinal: if (passEnd)
					state <= stIdle;
				default: ;
			endcase
		end
	end

	// ********************
	// run queues

	runQueue #(.Depth(Depth)) queue1A (.clk, .reset_n, .clear(start),
		.push(qPush[0]), .pushData(pushWord), .pop(qPop[0]),
		.head(qHead[0]), .count(qCount[0]));
	runQueue #(.Depth(Depth)) queue1B (.clk, .reset_n, .clear(start),
		.push(qPush[1]), .pushData(pushWord), .pop(qPop[1]),
		.head(qHead[1]), .count(qCount[1]));
	runQueue #(.Depth(Depth)) queue2A (.clk, .reset_n, .clear(start),
		.push(qPush[2]), .pushData(pushWord), .pop(qPop[2]),
		.head(qHead[2]), .count(qCount[2]));
	runQueue #(.Depth(Depth)) queue2B (.clk, .reset_n, .clear(start),
		.push(qPush[3]), .pushData(pushWord), .pop(qPop[3]),
		.head(qHead[3]), .count(qCount[3]));

endmodule

//--- hw/blockWriter.sv
`timescale 1ns/100ps

module blockWriter (
	input logic clk,
	input logic reset_n,
	input logic start,
	input sortPkg::job_t job,
	input sortPkg::sortedBeat_t sortedBeat,
	output logic sortedReady,
	input busPkg::memRsp_t memRsp,
	output busPkg::memReq_t memReq,
	output logic writeDone
);
	import sortPkg::*;

	logic pending;       // write held on the bus
	logic accepted;
	word_t writeWord;
	len_t writeIndex;

	assign sortedReady = !pending;
	assign accepted = pending && !memRsp.waitRequest;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pending <= 1'b0;
			writeIndex <= '0;
			writeDone <= 1'b0;
		end else begin
			writeDone <= accepted && (writeIndex == job.length - 1'b1);
			if (start)
				writeIndex <= '0;
			else if (accepted)
				writeIndex <= writeIndex + 1'b1;
			if (sortedBeat.valid && sortedReady)
				pending <= 1'b1;
			else if (accepted)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sortedBeat.valid && sortedReady)
			writeWord <= sortedBeat.data;
	end

	always_comb begin
		memReq = '0;
		memReq.write = pending;
		memReq.address = job.writeAddress + 32'(writeIndex);   // ascending from base
		memReq.writeData = writeWord;
	end

endmodule

//--- hw/sortSequencer.sv
`timescale 1ns/100ps

module sortSequencer #(
	parameter int MaxLength = 32
) (
	input logic clk,
	input logic reset_n,
	input logic ready,
	input logic [31:0] readAddress,
	input logic [31:0] writeAddress,
	input sortPkg::len_t length,
	input logic writeDone,
	input busPkg::memReq_t loadReq,
	input busPkg::memReq_t writeReq,
	output busPkg::memReq_t memReq,
	output sortPkg::job_t job,
	output logic start,
	output logic done
);
	typedef enum logic [1:0] {stIdle, stBusy, stDone} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= stIdle;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				stIdle: if (ready) begin
					state <= stBusy;
					start <= 1'b1;   // job register valid with it
				end
				stBusy: if (writeDone)
					state <= stDone;
				stDone: if (!ready)
					state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stIdle && ready)
			job <= '{readAddress: readAddress, writeAddress: writeAddress, length: length};
	end

	assign done = (state == stDone);
	assign memReq = writeReq.write ? writeReq : loadReq;   // only one side is ever active

	lengthLegal: assert property (@(posedge clk) disable iff (!reset_n)
		start |-> job.length >= 2 && job.length <= MaxLength
			&& (job.length & (job.length - 1'b1)) == '0);
	busExclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(loadReq.read && writeReq.write));

endmodule

//--- hw/sortTop.sv
`timescale 1ns/100ps

module sortTop #(
	parameter int MaxLength = 32
) (
	input logic clk,
	input logic reset_n,
	input logic ready,
	input logic [31:0] readAddress,
	input logic [31:0] writeAddress,
	input sortPkg::len_t length,
	input busPkg::memRsp_t memRsp,
	output busPkg::memReq_t memReq,
	output logic done
);
	import sortPkg::*;
	import busPkg::*;

	job_t job;
	logic start;
	sortedBeat_t loadBeat;
	sortedBeat_t sortedBeat;
	logic sortedReady;
	logic writeDone;
	memReq_t loadReq;
	memReq_t writeReq;

	sortSequencer #(.MaxLength(MaxLength)) sequencer (.clk, .reset_n, .ready,
		.readAddress, .writeAddress, .length, .writeDone, .loadReq, .writeReq,
		.memReq, .job, .start, .done);

	blockLoader loader (.clk, .reset_n, .start, .job, .memRsp,
		.memReq(loadReq), .loadBeat);

	mergeEngine #(.MaxLength(MaxLength)) engine (.clk, .reset_n, .start, .job,
		.loadBeat, .sortedBeat, .sortedReady);

	blockWriter writer (.clk, .reset_n, .start, .job, .sortedBeat, .sortedReady,
		.memRsp, .memReq(writeReq), .writeDone);

endmodule

//--- dv/sortMemModel.sv
`timescale 1ns/100ps

module sortMemModel (
	input logic clk,
	input logic reset_n,
	input logic heavyWait,          // wait states on about 3 of 4 cycles
	input logic pokeEn,             // preload port for source data
	input logic [7:0] pokeAddr,
	input logic [15:0] pokeData,
	input busPkg::memReq_t memReq,
	output busPkg::memRsp_t memRsp
);
	import busPkg::*;

	logic [15:0] store [256];
	logic [31:0] lfsr;
	int unsigned cycle;             // index of the cycle after this edge
	int unsigned lastDue;
	int unsigned dueQ [$];          // return cycle of each outstanding read
	logic [15:0] dataQ [$];

	// galois LFSR, one step per bit taken
	function automatic logic [1:0] takeBits(input int n);
		logic [1:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return bits;
	endfunction

	always @(posedge clk) begin
		logic [1:0] v;
		int unsigned due;
		if (!reset_n) begin
			lfsr = 32'he70c1f7b;
			cycle = 0;
			lastDue = 0;
			dueQ.delete();
			dataQ.delete();
			memRsp <= '0;
			for (int i = 0; i < 256; i++)
				store[i] <= {8'hd0, 8'(i)};   // background tracks the address
		end else begin
			cycle = cycle + 1;
			if (pokeEn)
				store[pokeAddr] <= pokeData;
			if (memReq.write && !memRsp.waitRequest)
				store[memReq.address[7:0]] <= memReq.writeData;
			if (memReq.read && !memRsp.waitRequest) begin
				v = takeBits(2);
				due = cycle + ((v == 2'd3) ? 0 : v);   // latency 1 to 3
				if (due <= lastDue)
					due = lastDue + 1;                 // keep returns in order
				lastDue = due;
				dueQ.push_back(due);
				dataQ.push_back(store[memReq.address[7:0]]);
			end
			memRsp.readDataValid <= 1'b0;
			if (dueQ.size() != 0 && dueQ[0] == cycle) begin
				memRsp.readDataValid <= 1'b1;
				memRsp.readData <= dataQ.pop_front();
				void'(dueQ.pop_front());
			end
			if (heavyWait)
				memRsp.waitRequest <= (takeBits(2) != 2'd0);
			else
				memRsp.waitRequest <= (takeBits(1) != 2'd0);
		end
	end

endmodule

//--- dv/sortTb.sv
`timescale 1ns/100ps

module sortTb;
	import sortPkg::*;
	import busPkg::*;

	localparam int NumJobs = 11;
	localparam int WordCycles = 40;   // watchdog budget per word

	logic clk = 1'b0;
	logic reset_n;
	logic ready;
	logic [31:0] readAddress;
	logic [31:0] writeAddress;
	len_t length;
	memReq_t memReq;
	memRsp_t memRsp;
	logic done;
	logic heavyWait;
	logic pokeEn;
	logic [7:0] pokeAddr;
	word_t pokeData;

	// kinds: 0 random, 1 all equal, 2 duplicates, 3 ascending, 4 descending
	int jobLen [NumJobs] = '{2, 4, 8, 16, 32, 32, 32, 16, 32, 32, 8};
	int jobKind [NumJobs] = '{0, 0, 0, 0, 0, 1, 2, 3, 4, 0, 0};
	word_t source [32];
	word_t expected [32];
	logic [31:0] lfsr = 32'he70c1f7b;
	int errors = 0;
	int writesSeen;
	int activeLen = 0;
	logic [31:0] activeBase = '0;

	always #2 clk = ~clk;

	sortTop #(.MaxLength(32)) sortTop_inst (.clk, .reset_n, .ready, .readAddress,
		.writeAddress, .length, .memRsp, .memReq, .done);

	sortMemModel memory (.clk, .reset_n, .heavyWait, .pokeEn, .pokeAddr, .pokeData,
		.memReq, .memRsp);

	// ********************
	// stimulus and reference

	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[14:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return bits;
	endfunction

	function automatic word_t makeWord(input int kind, input int i);
		case (kind)
			1: return 16'h5a5a;
			2: return 16'h0100 + randomBits(2);   // only four values
			3: return 16'(7 + 3 * i);
			4: return 16'(65520 - 5 * i);
			default: return randomBits(16);
		endcase
	endfunction

	// insertion sort of source into expected
	function automatic void referenceSort(input int len);
		word_t key;
		int j;
		for (int i = 0; i < len; i++)
			expected[i] = source[i];
		for (int i = 1; i < len; i++) begin
			key = expected[i];
			j = i - 1;
			while (j >= 0 && expected[j] > key) begin
				expected[j + 1] = expected[j];
				j--;
			end
			expected[j + 1] = key;
		end
	endfunction

	task automatic checkValue(input string name, input logic [31:0] want,
			input logic [31:0] got);
		if (got !== want) begin
			$display("ERR %s expected %h got %h at %0t", name, want, got, $time);
			errors++;
		end
	endtask

	// ********************
	// bus monitor

	always @(negedge clk) begin
		if (reset_n === 1'b1) begin
			if (memReq.read && memReq.write) begin
				$display("read and write requested in the same cycle at %0t", $time);
				errors++;
			end
			if (memReq.write && !memRsp.waitRequest) begin
				if (memReq.address < activeBase || memReq.address >= activeBase + activeLen) begin
					$display("write to address %h outside the result region", memReq.address);
					errors++;
				end else
					checkValue("writeData", 32'(expected[5'(memReq.address - activeBase)]),
						32'(memReq.writeData));
				writesSeen++;
			end
		end
	end

	task automatic runJob(input int j);
		int len;
		logic [31:0] rBase;
		logic [31:0] wBase;
		len = jobLen[j];
		rBase = 32'(16 + 4 * j);       // sources below 128, results above
		wBase = 32'(128 + 8 * j);
		heavyWait = (j >= 8);
		for (int i = 0; i < len; i++) begin
			source[i] = makeWord(jobKind[j], i);
			pokeEn = 1'b1;
			pokeAddr = 8'(rBase + 32'(i));
			pokeData = source[i];
			@(posedge clk);
			#1;
		end
		pokeEn = 1'b0;
		referenceSort(len);
		activeBase = wBase;
		activeLen = len;
		writesSeen = 0;
		readAddress = rBase;
		writeAddress = wBase;
		length = len_t'(len);
		ready = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!done);
		checkValue("writeCount", 32'(len), 32'(writesSeen));   // all writes before done
		repeat (4) begin
			@(posedge clk);
			#1;
			checkValue("done", 32'd1, 32'(done));
		end
		ready = 1'b0;
		@(posedge clk);
		#1;
		checkValue("done", 32'd0, 32'(done));
		for (int i = 0; i < len; i++) begin
			checkValue("resultWord", 32'(expected[i]), 32'(memory.store[8'(wBase + 32'(i))]));
			checkValue("sourceWord", 32'(source[i]), 32'(memory.store[8'(rBase + 32'(i))]));
		end
	endtask

	// ********************
	// main sequence and watchdog

	initial begin
		reset_n = 1'b0;
		ready = 1'b0;
		readAddress = '0;
		writeAddress = '0;
		length = '0;
		heavyWait = 1'b0;
		pokeEn = 1'b0;
		pokeAddr = '0;
		pokeData = '0;
		writesSeen = 0;
		repeat (16) @(posedge clk);
		#1;
		reset_n = 1'b1;
		for (int j = 0; j < NumJobs; j++)
			runJob(j);
		$display("%0d jobs run, %0d errors", NumJobs, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		int limit;
		limit = 0;
		for (int j = 0; j < NumJobs; j++)
			limit += WordCycles * jobLen[j];
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the sort did not finish, %0d errors",
			limit, errors);
		$display("Test failed");
		$finish;
	end

endmodule

//--- sources.f
hw/sortPkg.sv
hw/busPkg.sv
hw/runQueue.sv
hw/blockLoader.sv
hw/mergeEngine.sv
hw/blockWriter.sv
hw/sortSequencer.sv
hw/sortTop.sv
dv/sortMemModel.sv
dv/sortTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= sortTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
